// ==== hw/board_defines.svh ====
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// ---------------------------------------------------------------------
// Board pin widths
// ---------------------------------------------------------------------

`define BOARD_W_KEY    4
`define BOARD_W_SW     4
`define BOARD_W_LED    8
`define BOARD_W_DIGIT  8
`define BOARD_W_GPIO  16

// ---------------------------------------------------------------------
// Microphone and display timing
// ---------------------------------------------------------------------

`define MIC_W            24
// clk cycles per half sck period
`define I2S_SCK_DIV       8
`define I2S_SLOT_BITS    32
`define SEG_SCAN_CYCLES  16
`define HEX_DIGITS        6

`endif

// ==== hw/board_pkg.sv ====
`include "board_defines.svh"

package board_pkg;

    // ---------------------------------------------------------------------
    // Microphone data
    // ---------------------------------------------------------------------

    // One left-channel sample, two's complement
    typedef logic signed [`MIC_W - 1:0] mic_sample_t;

    // I2S lines driven toward the microphone
    typedef struct packed {
        logic sck;
        logic ws;
        logic lr;
    } i2s_pins_t;

    // ---------------------------------------------------------------------
    // Seven-segment lines
    // ---------------------------------------------------------------------

    // Active-high form, the board wrapper inverts them
    typedef struct packed {
        logic [7:0]                  abcdefgh;
        logic [`BOARD_W_DIGIT - 1:0] digit;
    } seg_pins_t;

endpackage

// ==== hw/slow_clk_gen.sv ====
module slow_clk_gen #(
    parameter int unsigned fast_clk_mhz = 50,
    parameter int unsigned slow_clk_hz  = 1
) (
    input  logic clk,
    input  logic rst_n,
    output logic slow_clk
);

    // Number of fast cycles per half period of the slow clock
    localparam int unsigned half_period = fast_clk_mhz * 500000 / slow_clk_hz;
    localparam int unsigned cnt_w       = $clog2(half_period + 1);

    logic [cnt_w - 1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end else if (cnt == cnt_w'(half_period - 1)) begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== hw/inmp441_mic_i2s_receiver.sv ====
`include "board_defines.svh"

module inmp441_mic_i2s_receiver
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sd,
    output i2s_pins_t   pins,
    output mic_sample_t value,
    output logic        sample_valid
);

    localparam int unsigned div_w = $clog2(`I2S_SCK_DIV);
    localparam int unsigned bit_w = $clog2(`I2S_SLOT_BITS);

    logic [div_w - 1:0]  div_cnt;
    logic [bit_w - 1:0]  bit_cnt;
    logic                sck;
    logic                ws;
    logic                tick;
    logic                rise_evt;
    logic                fall_evt;
    logic                left_end;
    logic [1:0]          pub_pipe;
    logic [`MIC_W - 1:0] shift;

    // ---------------------------------------------------------------------
    // Bit clock and word select
    // ---------------------------------------------------------------------

    assign tick     = (div_cnt == div_w'(`I2S_SCK_DIV - 1));
    assign rise_evt = tick && !sck;
    assign fall_evt = tick && sck;

    // Left slot ends on the falling edge that raises ws
    assign left_end = fall_evt && !ws && (bit_cnt == bit_w'(`I2S_SLOT_BITS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sck     <= 1'b0;
            ws      <= 1'b0;
            bit_cnt <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
                sck <= ~sck;
            if (fall_evt) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == bit_w'(`I2S_SLOT_BITS - 1))
                    ws <= ~ws;
            end
        end
    end

    // ---------------------------------------------------------------------
    // Data capture
    // ---------------------------------------------------------------------

    // MSB sits on the second rising edge of the left slot
    always_ff @(posedge clk) begin
        if (rise_evt && !ws && bit_cnt >= bit_w'(1) && bit_cnt <= bit_w'(`MIC_W))
            shift <= {shift[`MIC_W - 2:0], sd};
        if (pub_pipe[1])
            value <= shift;
    end

    // Two-stage delay from the slot end to the published sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pub_pipe     <= '0;
            sample_valid <= 1'b0;
        end else begin
            pub_pipe     <= {pub_pipe[0], left_end};
            sample_valid <= pub_pipe[1];
        end
    end

    assign pins.sck = sck;
    assign pins.ws  = ws;
    assign pins.lr  = 1'b0;   // lr low puts the microphone on the left slot

endmodule

// ==== hw/seven_segment_display.sv ====
`include "board_defines.svh"

module seven_segment_display
    import board_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`MIC_W - 1:0] word,
    input  logic                dp,
    output seg_pins_t           seg
);

    localparam int unsigned scan_w = $clog2(`SEG_SCAN_CYCLES);
    localparam int unsigned idx_w  = $clog2(`BOARD_W_DIGIT);

    logic [scan_w - 1:0] scan_cnt;
    logic [idx_w - 1:0]  digit_idx;
    logic [3:0]          nibble;
    logic [6:0]          segs;
    logic                shown;

    // ---------------------------------------------------------------------
    // Digit scan
    // ---------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == scan_w'(`SEG_SCAN_CYCLES - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // ---------------------------------------------------------------------
    // Hex decode, segments a..g
    // ---------------------------------------------------------------------

    assign shown  = (digit_idx < idx_w'(`HEX_DIGITS));
    assign nibble = 4'(word >> (4 * digit_idx));

    always_comb begin
        case (nibble)
            4'h0:    segs = 7'b1111110;
            4'h1:    segs = 7'b0110000;
            4'h2:    segs = 7'b1101101;
            4'h3:    segs = 7'b1111001;
            4'h4:    segs = 7'b0110011;
            4'h5:    segs = 7'b1011011;
            4'h6:    segs = 7'b1011111;
            4'h7:    segs = 7'b1110000;
            4'h8:    segs = 7'b1111111;
            4'h9:    segs = 7'b1111011;
            4'ha:    segs = 7'b1110111;
            4'hb:    segs = 7'b0011111;
            4'hc:    segs = 7'b1001110;
            4'hd:    segs = 7'b0111101;
            4'he:    segs = 7'b1001111;
            default: segs = 7'b1000111;
        endcase
    end

    // Upper digits stay dark, the point belongs to digit 0
    assign seg.abcdefgh = {shown ? segs : 7'b0, dp && (digit_idx == '0)};
    assign seg.digit    = `BOARD_W_DIGIT'(1) << digit_idx;

endmodule

// ==== hw/top.sv ====
`include "board_defines.svh"

module top
    import board_pkg::*;
#(
    parameter int unsigned clk_mhz = 50
) (
    input  logic                      clk,
    input  logic                      slow_clk,
    input  logic                      rst_n,
    input  logic [`BOARD_W_KEY - 2:0] key,
    input  mic_sample_t               value,
    input  logic                      sample_valid,
    output logic [`BOARD_W_LED - 1:0] led,
    output seg_pins_t                 seg
);

    // LED 0 lights once the peak reaches this bit
    localparam int unsigned led_base = `MIC_W - `BOARD_W_LED;

    logic [`MIC_W - 1:0] shown_word;
    logic [`MIC_W - 1:0] peak;
    logic [`MIC_W - 1:0] magnitude;
    logic                started;
    seg_pins_t           seg_raw;

    if (clk_mhz < 1) begin : g_bad_clk
        $error("clk_mhz must be at least 1");
    end

    // ---------------------------------------------------------------------
    // Sample hold and peak meter
    // ---------------------------------------------------------------------

    // The most negative sample maps to 2**23, which still fits unsigned
    assign magnitude = (value < 0) ? unsigned'(-value) : unsigned'(value);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shown_word <= '0;
            started    <= 1'b0;
        end else if (sample_valid) begin
            started <= 1'b1;
            if (!key[0])
                shown_word <= value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            peak <= '0;
        else if (key[1])
            peak <= '0;
        else if (sample_valid && magnitude > peak)
            peak <= magnitude;
    end

    // Bar length is the top set bit minus 15, clamped to 0..8
    always_comb begin
        for (int i = 0; i < `BOARD_W_LED; i++)
            led[i] = |(peak >> (led_base + i));
    end

    // ---------------------------------------------------------------------
    // Display
    // ---------------------------------------------------------------------

    seven_segment_display i_display (
        .clk   (clk),
        .rst_n (rst_n),
        .word  (shown_word),
        .dp    (slow_clk),
        .seg   (seg_raw)
    );

    // Dark until the first sample arrives
    assign seg = started ? seg_raw : '0;

endmodule

// ==== hw/board_specific_top.sv ====
`include "board_defines.svh"

module board_specific_top
    import board_pkg::*;
#(
    parameter int unsigned clk_mhz     = 50,
    parameter int unsigned slow_clk_hz = 1
) (
    input  logic                       CLK,

    input  logic [`BOARD_W_KEY - 1:0]  KEY,
    input  logic [`BOARD_W_SW - 1:0]   SW,
    output logic [`BOARD_W_LED - 1:0]  LED,

    output logic [7:0]                 ABCDEFGH,
    output logic [`BOARD_W_DIGIT - 1:0] DIGIT,

    output logic                       VGA_HSYNC,
    output logic                       VGA_VSYNC,
    output logic [2:0]                 VGA_RGB,

    input  logic                       UART_RXD,

    inout  wire  [`BOARD_W_GPIO - 1:0] GPIO
);

    // Top key is the reset, the rest go to the lab core
    localparam int unsigned w_top_key = `BOARD_W_KEY - 1;

    logic                      clk;
    logic                      rst_n;
    logic [w_top_key - 1:0]    top_key;
    logic                      slow_clk;
    logic [`BOARD_W_LED - 1:0] led;
    seg_pins_t                 seg;
    i2s_pins_t                 mic_pins;
    mic_sample_t               mic_value;
    logic                      mic_valid;

    assign clk     = CLK;
    assign rst_n   = KEY[w_top_key];
    assign top_key = ~KEY[w_top_key - 1:0];

    // ---------------------------------------------------------------------
    // Clocking and lab core
    // ---------------------------------------------------------------------

    slow_clk_gen #(
        .fast_clk_mhz (clk_mhz),
        .slow_clk_hz  (slow_clk_hz)
    ) i_slow_clk_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .slow_clk (slow_clk)
    );

    top #(
        .clk_mhz (clk_mhz)
    ) i_top (
        .clk          (clk),
        .slow_clk     (slow_clk),
        .rst_n        (rst_n),
        .key          (top_key),
        .value        (mic_value),
        .sample_valid (mic_valid),
        .led          (led),
        .seg          (seg)
    );

    // Board outputs are active low
    assign LED      = ~led;
    assign ABCDEFGH = ~seg.abcdefgh;
    assign DIGIT    = ~seg.digit;

    // No picture on VGA, syncs idle high
    assign VGA_HSYNC = 1'b1;
    assign VGA_VSYNC = 1'b1;
    assign VGA_RGB   = '0;

    // ---------------------------------------------------------------------
    // INMP441 on the GPIO header
    // ---------------------------------------------------------------------

    inmp441_mic_i2s_receiver i_microphone (
        .clk          (clk),
        .rst_n        (rst_n),
        .sd           (GPIO[5]),
        .pins         (mic_pins),
        .value        (mic_value),
        .sample_valid (mic_valid)
    );

    assign GPIO[0] = mic_pins.lr;
    assign GPIO[1] = 1'b0;        // Microphone ground
    assign GPIO[2] = mic_pins.ws;
    assign GPIO[3] = 1'b1;        // Microphone supply
    assign GPIO[4] = mic_pins.sck;

endmodule

// ==== tests/board_properties.sv ====
`include "board_defines.svh"

module board_properties (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        sck,
    input logic                        ws,
    input logic                        strobe,
    input logic [`BOARD_W_DIGIT - 1:0] digit
);

    // Word select moves together with a falling bit clock
    ws_on_falling_sck: assert property (
        @(posedge clk) disable iff (!rst_n) $changed(ws) |-> $fell(sck)
    ) else $error("ws changed away from a falling sck edge");

    strobe_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) strobe |=> !strobe
    ) else $error("sample_valid stayed high for more than one cycle");

    // One lit digit that moves up by one place, digit 7 wraps to digit 0
    digit_scan_order: assert property (
        @(posedge clk) disable iff (!rst_n)
            $changed(digit) |-> $onehot(digit) &&
                digit == {$past(digit[`BOARD_W_DIGIT - 2:0]),
                          $past(digit[`BOARD_W_DIGIT - 1])}
    ) else $error("digit lines left the one-hot scan order");

endmodule

bind inmp441_mic_i2s_receiver board_properties i_receiver_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .sck    (sck),
    .ws     (ws),
    .strobe (sample_valid),
    .digit  ('0)
);

bind seven_segment_display board_properties i_display_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .sck    (1'b0),
    .ws     (1'b0),
    .strobe (1'b0),
    .digit  (seg.digit)
);

// ==== tests/board_checker.sv ====
`include "board_defines.svh"

module board_checker
    import board_pkg::*;
(
    input  logic                        clk,
    input  logic [`BOARD_W_KEY - 1:0]   key_pins,
    input  logic [`BOARD_W_LED - 1:0]   led_pins,
    input  logic [7:0]                  seg_pins,
    input  logic [`BOARD_W_DIGIT - 1:0] digit_pins,
    input  logic                        ws,
    input  mic_sample_t                 sample,
    output int                          errors,
    output int                          strobes
);

    // Segments a..g for each hex value
    localparam logic [6:0] hex_seg [16] = '{
        7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,
        7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47
    };

    logic [`MIC_W - 1:0]         word_q;
    logic [`MIC_W - 1:0]         word_d;
    logic [`MIC_W - 1:0]         peak_q;
    logic [`MIC_W - 1:0]         peak_d;
    logic [`MIC_W - 1:0]         mag;
    logic                        started_q;
    logic                        started_d;
    logic                        prev_ws;
    logic                        strobe;
    logic [1:0]                  rise_q;
    logic [6:0]                  exp_seg;
    logic [`BOARD_W_LED - 1:0]   bar;
    logic [`BOARD_W_DIGIT - 1:0] lit;
    int                          top_bit;
    int                          idx;

    task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
        $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        errors++;
    endtask

    // Pins are stable at the falling edge, the model state follows the rising edge
    always @(negedge clk) begin
        if (!key_pins[`BOARD_W_KEY - 1]) begin
            word_d    = '0;
            peak_d    = '0;
            started_d = 1'b0;
            prev_ws   = 1'b0;
            rise_q    = '0;
            errors    = 0;
            strobes   = 0;
        end else begin
            word_q    = word_d;
            peak_q    = peak_d;
            started_q = started_d;

            // ---------------------------------------------------------------
            // Output checks
            // ---------------------------------------------------------------
            top_bit = 15;
            for (int b = 16; b < `MIC_W; b++)
                if (peak_q[b])
                    top_bit = b;
            bar = `BOARD_W_LED'((9'd1 << (top_bit - 15)) - 9'd1);
            if (led_pins !== ~bar)
                mismatch("LED bar", 32'(~led_pins), 32'(bar));

            lit = ~digit_pins;
            if (!started_q) begin
                if (lit !== '0 || seg_pins !== 8'hff)
                    mismatch("idle display pins", 32'({digit_pins, seg_pins}), 32'hffff);
            end else if (!$onehot(lit)) begin
                mismatch("active digit lines", 32'(lit), 32'h1);
            end else begin
                for (int j = 0; j < `BOARD_W_DIGIT; j++)
                    if (lit[j])
                        idx = j;
                exp_seg = (idx < `HEX_DIGITS) ? hex_seg[4'(word_q >> (4 * idx))] : 7'h00;
                if (seg_pins[7:1] !== ~exp_seg)
                    mismatch($sformatf("digit %0d segments", idx), 32'(~seg_pins[7:1]),
                             32'(exp_seg));
                if (idx != 0 && !seg_pins[0])
                    mismatch($sformatf("digit %0d point", idx), 32'(~seg_pins[0]), 32'h0);
            end

            // ---------------------------------------------------------------
            // Reference model
            // ---------------------------------------------------------------
            mag     = sample[`MIC_W - 1] ? `MIC_W'(-sample) : `MIC_W'(sample);
            strobe  = rise_q[1];
            rise_q  = {rise_q[0], ws && !prev_ws};
            prev_ws = ws;
            if (strobe) begin
                strobes++;
                started_d = 1'b1;
                // Held key 0 keeps the old word
                if (key_pins[0])
                    word_d = sample;
            end
            if (!key_pins[1])
                peak_d = '0;
            else if (strobe && mag > peak_q)
                peak_d = mag;
        end
    end

endmodule

// ==== tests/tb_board_specific_top.sv ====
`include "board_defines.svh"

module tb_board_specific_top
    import board_pkg::*;
();

    logic                        clk;
    logic [`BOARD_W_KEY - 1:0]   key;
    logic [`BOARD_W_SW - 1:0]    sw;
    logic                        uart_rxd;
    logic                        sd;
    wire  [`BOARD_W_GPIO - 1:0]  gpio;
    logic [`BOARD_W_LED - 1:0]   led;
    logic [7:0]                  abcdefgh;
    logic [`BOARD_W_DIGIT - 1:0] digit;
    logic                        vga_hsync;
    logic                        vga_vsync;
    logic [2:0]                  vga_rgb;
    mic_sample_t                 sent_sample;
    logic [31:0]                 lcg_state;
    logic                        prev_sck;
    logic                        prev_ws;
    logic                        timed_out;
    int                          bit_pos;
    int                          checker_errors;
    int                          strobes;
    int                          local_errors;
    int                          tests_passed;
    int                          tests_failed;

    assign gpio[5] = sd;

    board_specific_top #(
        .clk_mhz     (1),
        .slow_clk_hz (50000)
    ) i_board_specific_top (
        .CLK       (clk),
        .KEY       (key),
        .SW        (sw),
        .LED       (led),
        .ABCDEFGH  (abcdefgh),
        .DIGIT     (digit),
        .VGA_HSYNC (vga_hsync),
        .VGA_VSYNC (vga_vsync),
        .VGA_RGB   (vga_rgb),
        .UART_RXD  (uart_rxd),
        .GPIO      (gpio)
    );

    board_checker i_checker (
        .clk        (clk),
        .key_pins   (key),
        .led_pins   (led),
        .seg_pins   (abcdefgh),
        .digit_pins (digit),
        .ws         (gpio[2]),
        .sample     (sent_sample),
        .errors     (checker_errors),
        .strobes    (strobes)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Random level with a random shift so the LED bar sees short and long bars
    function automatic mic_sample_t new_sample();
        logic [31:0] raw;
        logic [31:0] amount;
        raw    = next_rand();
        amount = next_rand();
        return mic_sample_t'($signed(raw[31:8]) >>> amount[30:28]);
    endfunction

    // ---------------------------------------------------------------------
    // INMP441 model, sd changes after each falling sck edge
    // ---------------------------------------------------------------------
    always @(posedge clk) begin
        #1;
        if (!key[`BOARD_W_KEY - 1]) begin
            bit_pos  = 0;
            prev_sck = 1'b0;
            prev_ws  = 1'b0;
            sd       = 1'b0;
        end else begin
            if (prev_sck && !gpio[4]) begin
                if (prev_ws && !gpio[2]) begin
                    bit_pos     = 0;
                    sent_sample = new_sample();
                end else begin
                    bit_pos = bit_pos + 1;
                end
                // Left slot carries the sample MSB first, the rest reads as zero
                if (!gpio[2] && bit_pos >= 1 && bit_pos <= `MIC_W)
                    sd = sent_sample[`MIC_W - bit_pos];
                else
                    sd = 1'b0;
            end
            prev_sck = gpio[4];
            prev_ws  = gpio[2];
        end
    end

    task automatic skip_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Returns one time unit after the edge that raised ws
    task automatic wait_ws_rise();
        logic last;
        int   n;
        last = gpio[2];
        n    = 0;
        while (!timed_out && !(gpio[2] && !last)) begin
            last = gpio[2];
            skip_cycles(1);
            n++;
            if (n > 1200) begin
                timed_out = 1'b1;
                $display("Timeout: ws did not rise within 1200 cycles at time %0t", $time);
            end
        end
    endtask

    function automatic int error_total();
        return checker_errors + local_errors;
    endfunction

    task automatic note_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        local_errors++;
    endtask

    task automatic close_test(input string name, input int base);
        if (error_total() == base && !timed_out) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: not ok", name);
        end
    endtask

    initial begin
        int base;
        int first;
        int hold;
        int n;
        logic seen_on;
        logic seen_off;

        lcg_state    = 32'd95156;
        key          = 4'b0111;
        sw           = '0;
        uart_rxd     = 1'b1;
        sd           = 1'b0;
        timed_out    = 1'b0;
        local_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        sent_sample  = new_sample();
        skip_cycles(2);
        key[`BOARD_W_KEY - 1] = 1'b1;

        base = error_total();
        if (gpio[4] !== 1'b0 || gpio[2] !== 1'b0)
            note_error("sck or ws not low after reset");
        wait_ws_rise();
        if (led !== '1 || digit !== '1)
            note_error("board pins lit before the first sample");
        if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1 || vga_rgb !== '0)
            note_error("VGA pins not idle");
        if (gpio[0] !== 1'b0 || gpio[1] !== 1'b0 || gpio[3] !== 1'b1)
            note_error("microphone lr, ground or supply pin wrong");
        close_test("1 idle after reset", base);

        // Let the strobe of the first sample pass before counting
        base  = error_total();
        skip_cycles(3);
        first = strobes;
        repeat (6) wait_ws_rise();
        skip_cycles(3);
        if (strobes - first != 6)
            note_error($sformatf("checker saw %0d samples instead of 6", strobes - first));
        close_test("2 samples on display", base);

        // Freeze over a random number of new samples
        base   = error_total();
        key[0] = 1'b0;
        hold   = 2 + int'(next_rand() >> 31);
        repeat (hold) wait_ws_rise();
        skip_cycles(4);
        key[0] = 1'b1;
        close_test("3 display freeze", base);

        base = error_total();
        repeat (2) wait_ws_rise();
        skip_cycles(5);
        if (led === '1)
            note_error("LED bar dark before key 1");
        key[1] = 1'b0;
        skip_cycles(1 + int'(next_rand() >> 30));
        key[1] = 1'b1;
        skip_cycles(1);
        if (led !== '1)
            note_error("LED bar still lit after key 1");
        close_test("4 peak bar and clear", base);

        // Point of digit 0 only shows while that digit is scanned
        base     = error_total();
        seen_on  = 1'b0;
        seen_off = 1'b0;
        n        = 0;
        while (!(seen_on && seen_off) && n < 400) begin
            skip_cycles(1);
            n++;
            if (!digit[0]) begin
                if (abcdefgh[0])
                    seen_off = 1'b1;
                else
                    seen_on = 1'b1;
            end
        end
        if (!(seen_on && seen_off)) begin
            $display("Heartbeat stuck: digit 0 point did not change within 400 cycles");
            local_errors++;
        end
        close_test("5 heartbeat", base);

        skip_cycles(2);
        $display("Tests: %0d ok, %0d not ok, %0d errors, %0d samples checked",
                 tests_passed, tests_failed, error_total(), strobes);
        if (timed_out || error_total() != 0) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_board_specific_top
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***
PASS_MSG = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb.f ====
+incdir+hw
hw/board_pkg.sv
hw/slow_clk_gen.sv
hw/inmp441_mic_i2s_receiver.sv
hw/seven_segment_display.sv
hw/top.sv
hw/board_specific_top.sv
tests/board_properties.sv
tests/board_checker.sv
tests/tb_board_specific_top.sv
